/* include/fsa_defs.svh */
`ifndef FSA_DEFS_SVH
`define FSA_DEFS_SVH

// frame geometry
`define FSA_IMG_W 64
`define FSA_IMG_H 32

// coordinate widths, must cover the frame size
`define FSA_X_W 6
`define FSA_Y_W 5

// header search
`define FSA_THICK_TOL 2
`define FSA_THICK_HALF 3

`endif

/* hdl/fsa_img_pkg.sv */
`include "fsa_defs.svh"

package fsa_img_pkg;

	// column index
	typedef logic [`FSA_X_W-1:0] img_x_t;

	// row index, also used for fiber thickness
	typedef logic [`FSA_Y_W-1:0] img_y_t;

	// one extra bit so a full-height swing fits with its sign
	typedef logic signed [`FSA_Y_W:0] img_dy_t;

endpackage

/* hdl/fsa_ctl_pkg.sv */
package fsa_ctl_pkg;

	// order matters, the sequencer steps through them by increment
	typedef enum logic [1:0] {
		PASS_FIRST,
		PASS_M3,
		PASS_M2,
		PASS_LAST
	} scan_pass_t;

	typedef enum logic [1:0] {SEQ_IDLE, SEQ_SCAN, SEQ_FLUSH} seq_state_t;

endpackage

/* hdl/fsa_col_profile.sv */
`timescale 1ns/1ps
`include "fsa_defs.svh"

module fsa_col_profile
	import fsa_img_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   sof,
	input  logic   pix_valid,
	input  logic   pix,
	input  logic   busy,
	input  img_x_t rd_addr,
	output logic   col_val,
	output img_y_t col_top,
	output img_y_t col_bot,
	output logic   frame_done
);

	localparam img_x_t X_LAST = img_x_t'(`FSA_IMG_W - 1);
	localparam img_y_t Y_LAST = img_y_t'(`FSA_IMG_H - 1);

	logic [`FSA_IMG_W-1:0] val_mem;
	img_y_t                top_mem [`FSA_IMG_W];
	img_y_t                bot_mem [`FSA_IMG_W];

	logic   capture;
	img_x_t x_cnt;
	img_y_t y_cnt;
	logic   start;
	logic   take;
	img_x_t cur_x;
	img_y_t cur_y;
	logic   last_pix;
	logic   first_hit;

	// sof while busy never opens capture, so the whole frame is skipped
	assign start     = sof && pix_valid && !busy;
	assign take      = pix_valid && (capture || start);
	assign cur_x     = start ? '0 : x_cnt;
	assign cur_y     = start ? '0 : y_cnt;
	assign last_pix  = (cur_x == X_LAST) && (cur_y == Y_LAST);
	assign first_hit = start || !val_mem[cur_x];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			capture    <= 1'b0;
			x_cnt      <= '0;
			y_cnt      <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= take && last_pix;
			if (take) begin
				capture <= !last_pix;
				if (cur_x == X_LAST) begin
					x_cnt <= '0;
					y_cnt <= cur_y + img_y_t'(1);
				end else begin
					x_cnt <= cur_x + img_x_t'(1);
					y_cnt <= cur_y;
				end
			end
		end
	end

	// rows arrive top down, so the first hit is the top and the last one the bottom
	always_ff @(posedge clk) begin
		if (start)
			val_mem <= '0;
		if (take && pix) begin
			val_mem[cur_x] <= 1'b1;
			if (first_hit)
				top_mem[cur_x] <= cur_y;
			bot_mem[cur_x] <= cur_y;
		end
	end

	always_ff @(posedge clk) begin
		col_val <= val_mem[rd_addr];
		col_top <= top_mem[rd_addr];
		col_bot <= bot_mem[rd_addr];
	end

endmodule

/* hdl/fsa_scan_seq.sv */
`timescale 1ns/1ps
`include "fsa_defs.svh"

module fsa_scan_seq
	import fsa_img_pkg::*;
	import fsa_ctl_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   frame_done,
	output img_x_t rd_addr,
	input  logic   col_val,
	input  img_y_t col_top,
	input  img_y_t col_bot,
	output logic   rd_en_d3,
	output logic   hfirst_p3,
	output logic   hM3_p3,
	output logic   hM2_p3,
	output logic   hlast_p3,
	output logic   wfirst_p3,
	output logic   wlast_p3,
	output img_x_t x_d3,
	output logic   rd_val_outer_p3,
	output img_y_t rd_top_outer_p3,
	output img_y_t rd_bot_outer_p3,
	output logic   wr_sof_d3,
	output logic   busy
);

	localparam img_x_t     X_LAST     = img_x_t'(`FSA_IMG_W - 1);
	// covers the 3 pipe stages, the 3 detector stages and the offset step
	localparam logic [2:0] FLUSH_LAST = 3'd7;

	seq_state_t state;
	scan_pass_t pass;
	img_x_t     x_q;
	logic [2:0] flush_cnt;

	logic       en_d1;
	logic       en_d2;
	logic       fin_d1;
	logic       fin_d2;
	scan_pass_t pass_d1;
	scan_pass_t pass_d2;
	scan_pass_t pass_d3;
	img_x_t     x_d1;
	img_x_t     x_d2;
	logic       val_p2;
	img_y_t     top_p2;
	img_y_t     bot_p2;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state     <= SEQ_IDLE;
			pass      <= PASS_FIRST;
			x_q       <= '0;
			flush_cnt <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (frame_done) begin
						state <= SEQ_SCAN;
						pass  <= PASS_FIRST;
						x_q   <= '0;
					end
				end
				SEQ_SCAN: begin
					x_q <= x_q + img_x_t'(1);
					if (x_q == X_LAST) begin
						if (pass == PASS_LAST) begin
							state     <= SEQ_FLUSH;
							flush_cnt <= '0;
						end else begin
							pass <= scan_pass_t'(pass + 2'd1);
						end
					end
				end
				SEQ_FLUSH: begin
					flush_cnt <= flush_cnt + 3'd1;
					if (flush_cnt == FLUSH_LAST)
						state <= SEQ_IDLE;
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	assign rd_addr = x_q;

	// frame_done counts too, the table must not clear before the first read
	assign busy = frame_done || (state != SEQ_IDLE);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			en_d1     <= 1'b0;
			en_d2     <= 1'b0;
			rd_en_d3  <= 1'b0;
			fin_d1    <= 1'b0;
			fin_d2    <= 1'b0;
			wr_sof_d3 <= 1'b0;
		end else begin
			en_d1     <= (state == SEQ_SCAN);
			en_d2     <= en_d1;
			rd_en_d3  <= en_d2;
			fin_d1    <= (state == SEQ_FLUSH) && (flush_cnt == '0);
			fin_d2    <= fin_d1;
			wr_sof_d3 <= fin_d2;
		end
	end

	// table data shows up one stage after the address
	always_ff @(posedge clk) begin
		pass_d1         <= pass;
		pass_d2         <= pass_d1;
		pass_d3         <= pass_d2;
		x_d1            <= x_q;
		x_d2            <= x_d1;
		x_d3            <= x_d2;
		val_p2          <= col_val;
		top_p2          <= col_top;
		bot_p2          <= col_bot;
		rd_val_outer_p3 <= val_p2;
		rd_top_outer_p3 <= top_p2;
		rd_bot_outer_p3 <= bot_p2;
	end

	assign hfirst_p3 = rd_en_d3 && (pass_d3 == PASS_FIRST);
	assign hM3_p3    = rd_en_d3 && (pass_d3 == PASS_M3);
	assign hM2_p3    = rd_en_d3 && (pass_d3 == PASS_M2);
	assign hlast_p3  = rd_en_d3 && (pass_d3 == PASS_LAST);
	assign wfirst_p3 = rd_en_d3 && (x_d3 == '0);
	assign wlast_p3  = rd_en_d3 && (x_d3 == X_LAST);

endmodule

/* hdl/fsa_detect_edge.sv */
`timescale 1ns/1ps
`include "fsa_defs.svh"

module fsa_detect_edge
	import fsa_img_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,

	input  logic   wr_sof_d3,
	input  logic   rd_en_d3,
	input  logic   hM2_p3,
	input  logic   hM3_p3,
	input  logic   hfirst_p3,
	input  logic   hlast_p3,
	input  logic   wfirst_p3,
	input  logic   wlast_p3,
	input  img_x_t x_d3,
	input  logic   rd_val_outer_p3,
	input  img_y_t rd_top_outer_p3,
	input  img_y_t rd_bot_outer_p3,

	output logic   ana_done,
	output logic   res_lft_valid,
	output img_x_t res_lft_edge,
	output logic   res_lft_header_valid,
	output img_x_t res_lft_header_x,
	output logic   res_lft_corner_valid,
	output img_x_t res_lft_corner_top_x,
	output img_y_t res_lft_corner_top_y,
	output img_x_t res_lft_corner_bot_x,
	output img_y_t res_lft_corner_bot_y,
	output logic   res_rt_valid,
	output img_x_t res_rt_edge,
	output logic   res_rt_header_valid,
	output img_x_t res_rt_header_x,
	output logic   res_rt_corner_valid,
	output img_x_t res_rt_corner_top_x,
	output img_y_t res_rt_corner_top_y,
	output img_x_t res_rt_corner_bot_x,
	output img_y_t res_rt_corner_bot_y
);

	localparam int                WIN  = 2 * `FSA_THICK_HALF + 1;
	localparam img_x_t            HALF = img_x_t'(`FSA_THICK_HALF);
	localparam logic [`FSA_Y_W:0] TOL  = (`FSA_Y_W + 1)'(`FSA_THICK_TOL);

	// thickness within the band around the outer reference
	function automatic logic thick_ok(input img_y_t thick, input img_y_t ref_thick);
		logic [`FSA_Y_W:0] t;
		logic [`FSA_Y_W:0] r;
		t = {1'b0, thick};
		r = {1'b0, ref_thick};
		return (t + TOL >= r) && (t <= r + TOL);
	endfunction

	logic   rd_en_p4;
	logic   hm3_p4;
	logic   hm2_p4;
	logic   hlast_p4;
	logic   wfirst_p4;
	logic   wlast_p4;
	img_x_t x_p4;
	logic   val_p4;
	img_y_t top_p4;
	img_y_t bot_p4;
	img_y_t thick_p4;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en_p4  <= 1'b0;
			hm3_p4    <= 1'b0;
			hm2_p4    <= 1'b0;
			hlast_p4  <= 1'b0;
			wfirst_p4 <= 1'b0;
			wlast_p4  <= 1'b0;
		end else begin
			rd_en_p4  <= rd_en_d3;
			hm3_p4    <= hM3_p3;
			hm2_p4    <= hM2_p3;
			hlast_p4  <= hlast_p3;
			wfirst_p4 <= wfirst_p3;
			wlast_p4  <= wlast_p3;
		end
	end

	always_ff @(posedge clk) begin
		x_p4     <= x_d3;
		val_p4   <= rd_val_outer_p3;
		top_p4   <= rd_top_outer_p3;
		bot_p4   <= rd_bot_outer_p3;
		thick_p4 <= rd_bot_outer_p3 - rd_top_outer_p3;
	end

	logic   lft_run;
	logic   lft_valid;
	img_x_t lft_edge;
	img_y_t lft_ref;
	logic   rt_prev;
	logic   rt_valid;
	img_x_t rt_edge;
	img_y_t rt_ref;

	// edges and reference thickness, pass M3
	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_run   <= 1'b0;
			lft_valid <= 1'b0;
			rt_prev   <= 1'b0;
			rt_valid  <= 1'b0;
		end else if (rd_en_p4 && hm3_p4) begin
			if (wfirst_p4) begin
				lft_run   <= val_p4;
				lft_valid <= val_p4;
				lft_edge  <= '0;
				lft_ref   <= thick_p4;
			end else if (lft_run) begin
				if (val_p4)
					lft_edge <= x_p4;
				else
					lft_run <= 1'b0;
			end
			// start of the latest run, the one that reaches the last column
			if (val_p4 && (wfirst_p4 || !rt_prev))
				rt_edge <= x_p4;
			rt_prev <= val_p4;
			if (wlast_p4) begin
				rt_valid <= val_p4;
				rt_ref   <= thick_p4;
			end
		end
	end

	logic           lft_ok;
	logic           rt_ok;
	logic [WIN-1:0] lft_win;
	logic [WIN-1:0] rt_win;
	logic [WIN-1:0] lft_win_nx;
	logic [WIN-1:0] rt_win_nx;
	logic           lft_hdr_found;
	img_x_t         lft_hdr_x;
	logic           rt_hdr_found;
	img_x_t         rt_hdr_x;

	assign lft_ok = lft_valid && val_p4 && (x_p4 <= lft_edge) && thick_ok(thick_p4, lft_ref);
	assign rt_ok  = rt_valid && val_p4 && (x_p4 >= rt_edge) && thick_ok(thick_p4, rt_ref);
	assign lft_win_nx = {lft_win[WIN-2:0], lft_ok};
	assign rt_win_nx  = {rt_win[WIN-2:0], rt_ok};

	// header search, pass M2, first full window wins
	always_ff @(posedge clk) begin
		if (!resetn || (rd_en_d3 && hfirst_p3)) begin
			lft_hdr_found <= 1'b0;
			lft_win       <= '0;
			rt_hdr_found  <= 1'b0;
			rt_win        <= '0;
		end else if (rd_en_p4 && hm2_p4) begin
			lft_win <= lft_win_nx;
			rt_win  <= rt_win_nx;
			if (!lft_hdr_found && (&lft_win_nx)) begin
				lft_hdr_found <= 1'b1;
				lft_hdr_x     <= x_p4 - HALF;
			end
			if (!rt_hdr_found && (&rt_win_nx)) begin
				rt_hdr_found <= 1'b1;
				rt_hdr_x     <= x_p4 - HALF;
			end
		end
	end

	img_x_t lc_top_x;
	img_y_t lc_top_y;
	img_x_t lc_bot_x;
	img_y_t lc_bot_y;
	img_x_t rc_top_x;
	img_y_t rc_top_y;
	img_x_t rc_bot_x;
	img_y_t rc_bot_y;

	// tip corners, pass LAST; on a tie the point nearer the tip is kept
	always_ff @(posedge clk) begin
		if (rd_en_p4 && hlast_p4) begin
			if (lft_hdr_found && (x_p4 == lft_hdr_x)) begin
				lc_top_x <= x_p4;
				lc_top_y <= top_p4;
				lc_bot_x <= x_p4;
				lc_bot_y <= bot_p4;
			end else if (lft_hdr_found && (x_p4 > lft_hdr_x) && (x_p4 <= lft_edge)) begin
				if (top_p4 <= lc_top_y) begin
					lc_top_x <= x_p4;
					lc_top_y <= top_p4;
				end
				if (bot_p4 >= lc_bot_y) begin
					lc_bot_x <= x_p4;
					lc_bot_y <= bot_p4;
				end
			end
			// right tip is met first, so strict compares
			if (rt_hdr_found && (x_p4 == rt_edge)) begin
				rc_top_x <= x_p4;
				rc_top_y <= top_p4;
				rc_bot_x <= x_p4;
				rc_bot_y <= bot_p4;
			end else if (rt_hdr_found && (x_p4 > rt_edge) && (x_p4 <= rt_hdr_x)) begin
				if (top_p4 < rc_top_y) begin
					rc_top_x <= x_p4;
					rc_top_y <= top_p4;
				end
				if (bot_p4 > rc_bot_y) begin
					rc_bot_x <= x_p4;
					rc_bot_y <= bot_p4;
				end
			end
		end
	end

	logic wr_sof_d4;
	logic wr_sof_d5;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_sof_d4 <= 1'b0;
			wr_sof_d5 <= 1'b0;
			ana_done  <= 1'b0;
		end else begin
			wr_sof_d4 <= wr_sof_d3;
			wr_sof_d5 <= wr_sof_d4;
			ana_done  <= wr_sof_d5;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			res_lft_valid        <= 1'b0;
			res_lft_edge         <= '0;
			res_lft_header_valid <= 1'b0;
			res_lft_header_x     <= '0;
			res_lft_corner_valid <= 1'b0;
			res_lft_corner_top_x <= '0;
			res_lft_corner_top_y <= '0;
			res_lft_corner_bot_x <= '0;
			res_lft_corner_bot_y <= '0;
			res_rt_valid         <= 1'b0;
			res_rt_edge          <= '0;
			res_rt_header_valid  <= 1'b0;
			res_rt_header_x      <= '0;
			res_rt_corner_valid  <= 1'b0;
			res_rt_corner_top_x  <= '0;
			res_rt_corner_top_y  <= '0;
			res_rt_corner_bot_x  <= '0;
			res_rt_corner_bot_y  <= '0;
		end else if (wr_sof_d5) begin
			res_lft_valid        <= lft_valid;
			res_lft_edge         <= lft_edge;
			res_lft_header_valid <= lft_hdr_found;
			res_lft_header_x     <= lft_hdr_x;
			res_lft_corner_valid <= lft_hdr_found;
			res_lft_corner_top_x <= lc_top_x;
			res_lft_corner_top_y <= lc_top_y;
			res_lft_corner_bot_x <= lc_bot_x;
			res_lft_corner_bot_y <= lc_bot_y;
			res_rt_valid         <= rt_valid;
			res_rt_edge          <= rt_edge;
			res_rt_header_valid  <= rt_hdr_found;
			res_rt_header_x      <= rt_hdr_x;
			res_rt_corner_valid  <= rt_hdr_found;
			res_rt_corner_top_x  <= rc_top_x;
			res_rt_corner_top_y  <= rc_top_y;
			res_rt_corner_bot_x  <= rc_bot_x;
			res_rt_corner_bot_y  <= rc_bot_y;
		end
	end

endmodule

/* hdl/fsa_offset_calc.sv */
`timescale 1ns/1ps
`include "fsa_defs.svh"

module fsa_offset_calc
	import fsa_img_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,
	input  logic    ana_done,
	input  logic    res_lft_valid,
	input  img_x_t  res_lft_edge,
	input  logic    res_lft_corner_valid,
	input  img_y_t  res_lft_corner_top_y,
	input  img_y_t  res_lft_corner_bot_y,
	input  logic    res_rt_valid,
	input  img_x_t  res_rt_edge,
	input  logic    res_rt_corner_valid,
	input  img_y_t  res_rt_corner_top_y,
	input  img_y_t  res_rt_corner_bot_y,
	output logic    offset_valid,
	output img_x_t  gap,
	output img_dy_t dy,
	output logic    meas_ok
);

	logic [`FSA_Y_W:0] lft_sum;
	logic [`FSA_Y_W:0] rt_sum;
	img_y_t            lft_axis;
	img_y_t            rt_axis;

	// axis is the floor of the corner midpoint
	assign lft_sum  = {1'b0, res_lft_corner_top_y} + {1'b0, res_lft_corner_bot_y};
	assign rt_sum   = {1'b0, res_rt_corner_top_y} + {1'b0, res_rt_corner_bot_y};
	assign lft_axis = lft_sum[`FSA_Y_W:1];
	assign rt_axis  = rt_sum[`FSA_Y_W:1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			offset_valid <= 1'b0;
			gap          <= '0;
			dy           <= '0;
			meas_ok      <= 1'b0;
		end else begin
			offset_valid <= ana_done;
			if (ana_done) begin
				gap     <= res_rt_edge - res_lft_edge - img_x_t'(1);
				dy      <= img_dy_t'({1'b0, rt_axis}) - img_dy_t'({1'b0, lft_axis});
				meas_ok <= res_lft_valid && res_rt_valid &&
				           res_lft_corner_valid && res_rt_corner_valid;
			end
		end
	end

endmodule

/* hdl/fsa_analyzer.sv */
`timescale 1ns/1ps
`include "fsa_defs.svh"

module fsa_analyzer
	import fsa_img_pkg::*;
(
	input  logic    clk,
	input  logic    resetn,
	input  logic    sof,
	input  logic    pix_valid,
	input  logic    pix,
	output logic    busy,
	output logic    res_lft_valid,
	output img_x_t  res_lft_edge,
	output logic    res_lft_header_valid,
	output img_x_t  res_lft_header_x,
	output logic    res_lft_corner_valid,
	output img_x_t  res_lft_corner_top_x,
	output img_y_t  res_lft_corner_top_y,
	output img_x_t  res_lft_corner_bot_x,
	output img_y_t  res_lft_corner_bot_y,
	output logic    res_rt_valid,
	output img_x_t  res_rt_edge,
	output logic    res_rt_header_valid,
	output img_x_t  res_rt_header_x,
	output logic    res_rt_corner_valid,
	output img_x_t  res_rt_corner_top_x,
	output img_y_t  res_rt_corner_top_y,
	output img_x_t  res_rt_corner_bot_x,
	output img_y_t  res_rt_corner_bot_y,
	output logic    offset_valid,
	output img_x_t  gap,
	output img_dy_t dy,
	output logic    meas_ok
);

	// column table read port
	img_x_t rd_addr;
	logic   col_val;
	img_y_t col_top;
	img_y_t col_bot;
	logic   frame_done;

	// scan stream into the detector
	logic   rd_en_d3;
	logic   hfirst_p3;
	logic   hM3_p3;
	logic   hM2_p3;
	logic   hlast_p3;
	logic   wfirst_p3;
	logic   wlast_p3;
	img_x_t x_d3;
	logic   rd_val_outer_p3;
	img_y_t rd_top_outer_p3;
	img_y_t rd_bot_outer_p3;
	logic   wr_sof_d3;
	logic   ana_done;

	fsa_col_profile u_col_profile (.*);

	fsa_scan_seq u_scan_seq (.*);

	fsa_detect_edge u_detect_edge (.*);

	fsa_offset_calc u_offset_calc (.*);

endmodule

/* dv/fsa_tb.sv */
`timescale 1ns/1ps
`include "fsa_defs.svh"

module fsa_tb
	import fsa_img_pkg::*;
();

	localparam int W        = `FSA_IMG_W;
	localparam int H        = `FSA_IMG_H;
	localparam int TOL      = `FSA_THICK_TOL;
	localparam int HALF     = `FSA_THICK_HALF;
	localparam int WIN      = 2 * HALF + 1;
	localparam int N_RANDOM = 40;
	localparam int N_FRAMES = N_RANDOM + 4;
	// last pixel to offset_valid
	localparam int LATENCY  = 1 + 4 + 4 * W + 1 + 3;
	localparam int WAIT_MAX = LATENCY + 50;
	localparam longint WATCHDOG_NS = longint'(N_FRAMES) * (W * H * 2 + 300) * 20;

	logic    clk = 1'b0;
	logic    resetn;
	logic    sof;
	logic    pix_valid;
	logic    pix;
	logic    busy;
	logic    res_lft_valid;
	img_x_t  res_lft_edge;
	logic    res_lft_header_valid;
	img_x_t  res_lft_header_x;
	logic    res_lft_corner_valid;
	img_x_t  res_lft_corner_top_x;
	img_y_t  res_lft_corner_top_y;
	img_x_t  res_lft_corner_bot_x;
	img_y_t  res_lft_corner_bot_y;
	logic    res_rt_valid;
	img_x_t  res_rt_edge;
	logic    res_rt_header_valid;
	img_x_t  res_rt_header_x;
	logic    res_rt_corner_valid;
	img_x_t  res_rt_corner_top_x;
	img_y_t  res_rt_corner_top_y;
	img_x_t  res_rt_corner_bot_x;
	img_y_t  res_rt_corner_bot_y;
	logic    offset_valid;
	img_x_t  gap;
	img_dy_t dy;
	logic    meas_ok;

	fsa_analyzer UUT (.*);

	always #10 clk = ~clk;

	logic img [H][W];
	int   tv [W];
	int   tt [W];
	int   tb [W];

	// expected results of the current frame
	int e_lv, e_le, e_rv, e_re;
	int e_lhf, e_lhx, e_rhf, e_rhx;
	int e_ltx, e_lty, e_lbx, e_lby;
	int e_rtx, e_rty, e_rbx, e_rby;
	int e_ok, e_gap, e_dy;

	int cyc = 0;
	int ov_count = 0;
	int ov_cyc = 0;
	int last_cyc;
	int checks = 0;
	int errors = 0;
	int unsigned seed_ret;

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (offset_valid) begin
			ov_count <= ov_count + 1;
			ov_cyc   <= cyc;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run hung waiting for the DUT");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check_val(input string name, input int exp_v, input int act_v);
		checks++;
		assert (exp_v == act_v) else begin
			$display("FAIL %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic check_cond(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int c_start, input int e_start);
		$display("test %s done: %0d checks, %0d errors", name, checks - c_start,
			errors - e_start);
	endtask

	// thickness is bot - top; taper widens the fiber away from its outer end
	task automatic paint_fiber(input int x0, input int x1, input int tip_x, input int outer_x,
		input int top, input int thick, input int round_amt, input int taper);
		int t;
		int tp;
		int bt;
		int d;
		int trim;
		for (int x = x0; x <= x1; x++) begin
			d = (x > outer_x) ? x - outer_x : outer_x - x;
			t = thick;
			if (taper != 0)
				t = thick + ((d / 2 < 4) ? d / 2 : 4);
			tp = top;
			bt = top + t;
			d = (x > tip_x) ? x - tip_x : tip_x - x;
			if (d < 3) begin
				trim = (round_amt * (3 - d) + 1) / 2;
				tp = tp + trim;
				bt = bt - trim;
				if (tp > bt) begin
					tp = top + t / 2;
					bt = tp;
				end
			end
			for (int y = tp; y <= bt; y++)
				img[y][x] = 1'b1;
		end
	endtask

	// taper_side 1 tapers the left fiber, 2 the right one
	task automatic gen_frame(input int left_on, input int right_on, input int taper_side);
		int le;
		int re;
		int tl;
		int tr;
		int topl;
		int topr;
		int rl;
		int rr;
		for (int y = 0; y < H; y++)
			for (int x = 0; x < W; x++)
				img[y][x] = 1'b0;
		le   = int'($urandom_range(28, 20));
		re   = le + int'($urandom_range(12, 4)) + 1;
		tl   = int'($urandom_range(14, 6));
		tr   = int'($urandom_range(14, 6));
		topl = int'($urandom_range(27 - tl, 0));
		topr = int'($urandom_range(27 - tr, 0));
		rl   = int'($urandom_range(3, 0));
		rr   = int'($urandom_range(3, 0));
		if (left_on != 0)
			paint_fiber(0, le, le, 0, topl, tl, rl, (taper_side == 1) ? 1 : 0);
		if (right_on != 0)
			paint_fiber(re, W - 1, re, W - 1, topr, tr, rr, (taper_side == 2) ? 1 : 0);
	endtask

	task automatic build_model();
		int cnt;
		int th;
		int lref;
		int rref;
		for (int x = 0; x < W; x++) begin
			tv[x] = 0;
			for (int y = 0; y < H; y++) begin
				if (img[y][x]) begin
					if (tv[x] == 0)
						tt[x] = y;
					tb[x] = y;
					tv[x] = 1;
				end
			end
		end
		// edges from the runs touching the outer columns
		e_lv = tv[0];
		e_le = 0;
		if (e_lv != 0)
			while (e_le < W - 1 && tv[e_le + 1] != 0)
				e_le++;
		e_rv = tv[W - 1];
		e_re = W - 1;
		while (e_re > 0 && tv[e_re - 1] != 0)
			e_re--;
		lref = tb[0] - tt[0];
		rref = tb[W - 1] - tt[W - 1];
		e_lhf = 0;
		e_rhf = 0;
		cnt = 0;
		if (e_lv != 0) begin
			for (int x = 0; x <= e_le; x++) begin
				th = tb[x] - tt[x];
				cnt = (th >= lref - TOL && th <= lref + TOL) ? cnt + 1 : 0;
				if (cnt >= WIN && e_lhf == 0) begin
					e_lhf = 1;
					e_lhx = x - HALF;
				end
			end
		end
		cnt = 0;
		if (e_rv != 0) begin
			for (int x = e_re; x < W; x++) begin
				th = tb[x] - tt[x];
				cnt = (th >= rref - TOL && th <= rref + TOL) ? cnt + 1 : 0;
				if (cnt >= WIN && e_rhf == 0) begin
					e_rhf = 1;
					e_rhx = x - HALF;
				end
			end
		end
		// corners between header and tip, ties go to the point nearer the tip
		if (e_lhf != 0) begin
			e_ltx = e_lhx;
			e_lty = tt[e_lhx];
			e_lbx = e_lhx;
			e_lby = tb[e_lhx];
			for (int x = e_lhx + 1; x <= e_le; x++) begin
				if (tt[x] <= e_lty) begin
					e_ltx = x;
					e_lty = tt[x];
				end
				if (tb[x] >= e_lby) begin
					e_lbx = x;
					e_lby = tb[x];
				end
			end
		end
		if (e_rhf != 0) begin
			e_rtx = e_re;
			e_rty = tt[e_re];
			e_rbx = e_re;
			e_rby = tb[e_re];
			for (int x = e_re + 1; x <= e_rhx; x++) begin
				if (tt[x] < e_rty) begin
					e_rtx = x;
					e_rty = tt[x];
				end
				if (tb[x] > e_rby) begin
					e_rbx = x;
					e_rby = tb[x];
				end
			end
		end
		e_ok  = (e_lv != 0 && e_rv != 0 && e_lhf != 0 && e_rhf != 0) ? 1 : 0;
		e_gap = (e_re - e_le - 1) & (W - 1);
		e_dy  = (e_rty + e_rby) / 2 - (e_lty + e_lby) / 2;
	endtask

	task automatic send_frame();
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				@(posedge clk);
				sof       <= (x == 0 && y == 0);
				pix_valid <= 1'b1;
				pix       <= img[y][x];
				if (x == W - 1 && y == H - 1)
					last_cyc = cyc + 1;
				if ($urandom_range(7, 0) == 0) begin
					repeat ($urandom_range(2, 1)) begin
						@(posedge clk);
						sof       <= 1'b0;
						pix_valid <= 1'b0;
					end
				end
			end
		end
		@(posedge clk);
		sof       <= 1'b0;
		pix_valid <= 1'b0;
		pix       <= 1'b0;
	endtask

	task automatic wait_offset(input int start_count, output bit seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_MAX) begin
			@(posedge clk);
			n++;
			if (ov_count != start_count)
				seen = 1'b1;
		end
	endtask

	task automatic check_results();
		check_val("res_lft_valid", e_lv, int'(res_lft_valid));
		if (e_lv != 0)
			check_val("res_lft_edge", e_le, int'(res_lft_edge));
		check_val("res_rt_valid", e_rv, int'(res_rt_valid));
		if (e_rv != 0)
			check_val("res_rt_edge", e_re, int'(res_rt_edge));
		check_val("res_lft_header_valid", e_lhf, int'(res_lft_header_valid));
		check_val("res_lft_corner_valid", e_lhf, int'(res_lft_corner_valid));
		if (e_lhf != 0) begin
			check_val("res_lft_header_x", e_lhx, int'(res_lft_header_x));
			check_val("res_lft_corner_top_x", e_ltx, int'(res_lft_corner_top_x));
			check_val("res_lft_corner_top_y", e_lty, int'(res_lft_corner_top_y));
			check_val("res_lft_corner_bot_x", e_lbx, int'(res_lft_corner_bot_x));
			check_val("res_lft_corner_bot_y", e_lby, int'(res_lft_corner_bot_y));
		end
		check_val("res_rt_header_valid", e_rhf, int'(res_rt_header_valid));
		check_val("res_rt_corner_valid", e_rhf, int'(res_rt_corner_valid));
		if (e_rhf != 0) begin
			check_val("res_rt_header_x", e_rhx, int'(res_rt_header_x));
			check_val("res_rt_corner_top_x", e_rtx, int'(res_rt_corner_top_x));
			check_val("res_rt_corner_top_y", e_rty, int'(res_rt_corner_top_y));
			check_val("res_rt_corner_bot_x", e_rbx, int'(res_rt_corner_bot_x));
			check_val("res_rt_corner_bot_y", e_rby, int'(res_rt_corner_bot_y));
		end
		check_val("meas_ok", e_ok, int'(meas_ok));
		if (e_ok != 0) begin
			check_val("gap", e_gap, int'(gap));
			check_val("dy", e_dy, int'(dy));
		end
	endtask

	// one frame through the DUT, checked against the model
	task automatic run_frame(input int left_on, input int right_on, input int taper_side);
		int c0;
		bit seen;
		gen_frame(left_on, right_on, taper_side);
		build_model();
		c0 = ov_count;
		send_frame();
		wait_offset(c0, seen);
		check_cond(seen, "offset_valid never arrived after the frame");
		if (seen) begin
			check_val("offset_valid latency", LATENCY, ov_cyc - last_cyc);
			check_results();
		end
		repeat (4) @(posedge clk);
		check_cond(ov_count == c0 + 1, "frame produced more than one offset_valid");
	endtask

	initial begin
		int c_start;
		int e_start;
		int c0;
		int taper_sel;
		seed_ret = $urandom(28);
		resetn    <= 1'b0;
		sof       <= 1'b0;
		pix_valid <= 1'b0;
		pix       <= 1'b0;
		repeat (8) @(posedge clk);
		resetn <= 1'b1;

		c_start = checks;
		e_start = errors;
		repeat (50) begin
			@(posedge clk);
			check_cond(!busy && !UUT.ana_done && !offset_valid,
				"busy or a done strobe went high with no frame sent");
		end
		check_val("res_lft_valid", 0, int'(res_lft_valid));
		check_val("res_rt_valid", 0, int'(res_rt_valid));
		check_val("res_lft_header_valid", 0, int'(res_lft_header_valid));
		check_val("res_rt_header_valid", 0, int'(res_rt_header_valid));
		check_val("res_lft_corner_valid", 0, int'(res_lft_corner_valid));
		check_val("res_rt_corner_valid", 0, int'(res_rt_corner_valid));
		check_val("meas_ok", 0, int'(meas_ok));
		report_test("reset idle", c_start, e_start);

		// some frames taper one fiber so that no header exists
		c_start = checks;
		e_start = errors;
		for (int i = 0; i < N_RANDOM; i++) begin
			taper_sel = (i % 8 == 3) ? 1 : ((i % 8 == 6) ? 2 : 0);
			run_frame(1, 1, taper_sel);
		end
		report_test("random two fiber frames", c_start, e_start);

		c_start = checks;
		e_start = errors;
		run_frame(1, 0, 0);
		report_test("left fiber only", c_start, e_start);

		// second frame starts right after the first, while analysis runs
		c_start = checks;
		e_start = errors;
		gen_frame(1, 1, 0);
		build_model();
		c0 = ov_count;
		send_frame();
		gen_frame(1, 1, 0);
		send_frame();
		repeat (LATENCY + 20) @(posedge clk);
		check_val("offset_valid count", 1, ov_count - c0);
		check_results();
		report_test("frame dropped while busy", c_start, e_start);

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* fsa_analyzer.f */
+incdir+include
hdl/fsa_img_pkg.sv
hdl/fsa_ctl_pkg.sv
hdl/fsa_col_profile.sv
hdl/fsa_scan_seq.sv
hdl/fsa_detect_edge.sv
hdl/fsa_offset_calc.sv
hdl/fsa_analyzer.sv
dv/fsa_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fsa_tb -f fsa_analyzer.f -o fsa_sim

sim_out=$(./obj_dir/fsa_sim)
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
